// File: hdl/ctrl_reg_pkg.sv
package ctrl_reg_pkg;

  // Host bus word and register width
  typedef logic [15:0] data_t;
  // Register index as seen on the host bus
  typedef logic [7:0]  addr_t;
  // Byte enables, bit 0 low byte, bit 1 high byte
  typedef logic [1:0]  be_t;
  // Register kind code used by the map table
  typedef logic [1:0]  reg_kind_t;

  localparam reg_kind_t KIND_RW  = 2'd0; // Host read/write
  localparam reg_kind_t KIND_RO  = 2'd1; // Captured from status input
  localparam reg_kind_t KIND_W1C = 2'd2; // Interrupt status, write one to clear

  localparam int MAP_SIZE = 8; // Entries in the register map

  // Index of the interrupt status register
  localparam int IRQ_IDX = 6;

  // Kind of each register, index 0 first
  localparam reg_kind_t REG_KIND [0:MAP_SIZE-1] = '{
    KIND_RW,   // CTRL
    KIND_RW,   // MODE
    KIND_RW,   // SCROLL_X
    KIND_RW,   // SCROLL_Y
    KIND_RO,   // STATUS
    KIND_RO,   // FRAME_COUNT
    KIND_W1C,  // IRQ_STATUS
    KIND_RW    // SCRATCH
  };

  // Reset value of each register, index 0 first
  localparam data_t REG_RESET [0:MAP_SIZE-1] = '{
    16'h0000,  // CTRL
    16'h0011,  // MODE
    16'h0000,  // SCROLL_X
    16'h0000,  // SCROLL_Y
    16'h0000,  // STATUS
    16'h0000,  // FRAME_COUNT
    16'h0000,  // IRQ_STATUS
    16'hA5A5   // SCRATCH
  };

endpackage

// File: hdl/reg_write_if.sv
`timescale 1ns/100ps

// Decoded host write, fanned out to every register slice
interface reg_write_if #(
  parameter int NUM_REGS = 8
);

  logic                  wr;    // Single cycle write strobe
  logic [NUM_REGS-1:0]   sel;   // One-hot register select
  ctrl_reg_pkg::be_t     be;    // Byte enables of the write
  ctrl_reg_pkg::data_t   wdata; // Write data

  // Decoder side drives the write
  modport decoder (
    output wr,
    output sel,
    output be,
    output wdata
  );

  // Each slice only listens
  modport slice (
    input wr,
    input sel,
    input be,
    input wdata
  );

endinterface

// File: hdl/reg_bus_decoder.sv
`timescale 1ns/100ps

module reg_bus_decoder #(
  parameter int NUM_REGS = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                bus_en,    // One cycle request strobe
  input  logic                bus_wr,    // 1 write, 0 read
  input  ctrl_reg_pkg::be_t   bus_be,
  input  ctrl_reg_pkg::addr_t bus_addr,
  input  ctrl_reg_pkg::data_t bus_wdata,
  reg_write_if.decoder        wif,
  output logic                rd,        // Legal read, one cycle
  output ctrl_reg_pkg::addr_t rd_addr,
  output logic                err        // Illegal access, one cycle
);

  logic                in_range; // Address hits a built register
  logic                is_ro;    // Address hits a read-only register
  logic [NUM_REGS-1:0] sel_d;    // One-hot decode of bus_addr
  logic                wr_ok;
  logic                rd_ok;

  assign in_range = (bus_addr < NUM_REGS);

  // Table lookup, walked as a loop so unmapped addresses never index the table
  always_comb begin
    is_ro = 1'b0;
    for (int i = 0; i < ctrl_reg_pkg::MAP_SIZE; i++) begin
      if (bus_addr == ctrl_reg_pkg::addr_t'(i) &&
          ctrl_reg_pkg::REG_KIND[i] == ctrl_reg_pkg::KIND_RO) begin
        is_ro = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_REGS; i++) begin
      sel_d[i] = (bus_addr == ctrl_reg_pkg::addr_t'(i));
    end
  end

  assign wr_ok = bus_en & bus_wr & in_range & ~is_ro; // RO writes never strobe
  assign rd_ok = bus_en & ~bus_wr & in_range;

  // Request strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wif.wr <= 1'b0;
      rd     <= 1'b0;
      err    <= 1'b0;
    end else begin
      wif.wr <= wr_ok;
      rd     <= rd_ok;
      // Unmapped address either way, or a write to a status register
      err    <= bus_en & (~in_range | (bus_wr & is_ro));
    end
  end

  // Request payload, only meaningful alongside a strobe
  always_ff @(posedge clk) begin
    wif.sel   <= sel_d;
    wif.be    <= bus_be;
    wif.wdata <= bus_wdata;
    rd_addr   <= bus_addr;
  end

endmodule

// File: hdl/reg_slice.sv
`timescale 1ns/100ps

module reg_slice #(
  parameter int IDX = 0 // Register index in the map table
) (
  input  logic                clk,
  input  logic                rst_n,
  reg_write_if.slice          wif,
  input  ctrl_reg_pkg::data_t status, // Status word, RO kind only
  input  ctrl_reg_pkg::data_t set,    // Interrupt set bits, W1C kind only
  output ctrl_reg_pkg::data_t value
);

  localparam ctrl_reg_pkg::reg_kind_t KIND      = ctrl_reg_pkg::REG_KIND[IDX];
  localparam ctrl_reg_pkg::data_t     RESET_VAL = ctrl_reg_pkg::REG_RESET[IDX];

  logic                hit;    // This slice is written this cycle
  ctrl_reg_pkg::data_t bmask;  // Bit mask of the enabled bytes
  ctrl_reg_pkg::data_t clr;    // Bits written with one
  ctrl_reg_pkg::data_t next;

  assign hit   = wif.wr & wif.sel[IDX];
  assign bmask = {{8{wif.be[1]}}, {8{wif.be[0]}}};
  assign clr   = hit ? (wif.wdata & bmask) : '0;

  // Next value by register kind
  always_comb begin
    next = value;
    case (KIND)
      ctrl_reg_pkg::KIND_RW: begin
        if (hit) begin
          next = (value & ~bmask) | (wif.wdata & bmask); // Merge enabled bytes
        end
      end
      ctrl_reg_pkg::KIND_RO: begin
        next = status; // Track status every cycle
      end
      ctrl_reg_pkg::KIND_W1C: begin
        // Clear first, then set, so a simultaneous set wins
        next = (value & ~clr) | set;
      end
      default: begin
        next = value;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= RESET_VAL;
    end else begin
      value <= next;
    end
  end

endmodule

// File: hdl/reg_read_mux.sv
`timescale 1ns/100ps

module reg_read_mux #(
  parameter int NUM_REGS = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               rd,      // Legal read from decoder
  input  logic                               err,     // Illegal access from decoder
  input  ctrl_reg_pkg::addr_t                rd_addr,
  input  ctrl_reg_pkg::data_t [NUM_REGS-1:0] values,  // All slice outputs
  output ctrl_reg_pkg::data_t                rdata,
  output logic                               rvalid,
  output logic                               irq
);

  ctrl_reg_pkg::data_t sel_val; // Addressed slice value

  // Loop select keeps an out of range rd_addr off the array index
  always_comb begin
    sel_val = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (rd_addr == ctrl_reg_pkg::addr_t'(i)) begin
        sel_val = values[i];
      end
    end
  end

  // One response per request, errors included
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd | err;
    end
  end

  // Error responses carry zero data
  always_ff @(posedge clk) begin
    rdata <= rd ? sel_val : '0;
  end

  // Interrupt line, one cycle behind IRQ_STATUS
  if (ctrl_reg_pkg::IRQ_IDX < NUM_REGS) begin : g_irq
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        irq <= 1'b0;
      end else begin
        irq <= |values[ctrl_reg_pkg::IRQ_IDX];
      end
    end
  end else begin : g_no_irq
    assign irq = 1'b0; // Interrupt register not built
  end

endmodule

// File: hdl/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs #(
  parameter int NUM_REGS = 8 // Registers built, 1 to MAP_SIZE
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // Host bus
  input  logic                               bus_en,
  input  logic                               bus_wr,
  input  ctrl_reg_pkg::be_t                  bus_be,
  input  ctrl_reg_pkg::addr_t                bus_addr,
  input  ctrl_reg_pkg::data_t                bus_wdata,
  output ctrl_reg_pkg::data_t                bus_rdata,
  output logic                               bus_rvalid,
  output logic                               bus_err,
  // Engine side
  input  ctrl_reg_pkg::data_t [NUM_REGS-1:0] status_in,   // Feeds RO registers
  input  ctrl_reg_pkg::data_t                irq_set,     // Interrupt set pulses
  output ctrl_reg_pkg::data_t [NUM_REGS-1:0] ctrl_values, // Current register values
  output logic                               irq
);

  reg_write_if #(.NUM_REGS(NUM_REGS)) wif (); // Decoded write bus

  logic                               rd;
  ctrl_reg_pkg::addr_t                rd_addr;
  logic                               err;
  ctrl_reg_pkg::data_t [NUM_REGS-1:0] values;

  reg_bus_decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_en    (bus_en),
    .bus_wr    (bus_wr),
    .bus_be    (bus_be),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .wif       (wif.decoder),
    .rd        (rd),
    .rd_addr   (rd_addr),
    .err       (err)
  );

  // One slice per built register
  for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
    reg_slice #(.IDX(i)) u_slice (
      .clk    (clk),
      .rst_n  (rst_n),
      .wif    (wif.slice),
      .status (status_in[i]),
      // Only the interrupt register sees the set pulses
      .set    ((i == ctrl_reg_pkg::IRQ_IDX) ? irq_set : ctrl_reg_pkg::data_t'(0)),
      .value  (values[i])
    );
  end

  reg_read_mux #(.NUM_REGS(NUM_REGS)) u_read_mux (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd      (rd),
    .err     (err),
    .rd_addr (rd_addr),
    .values  (values),
    .rdata   (bus_rdata),
    .rvalid  (bus_rvalid),
    .irq     (irq)
  );

  // Error flag rides one stage behind the decoder, next to rvalid
  logic err_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err;
    end
  end

  assign bus_err     = err_q;
  assign ctrl_values = values;

endmodule

// File: tb/ctrl_regs_tb.sv
`timescale 1ns/100ps

module ctrl_regs_tb;

  localparam int N_RW  = 40; // Random RW write/read pairs
  localparam int N_RO  = 6;  // Status updates
  localparam int N_BAD = 8;  // Unmapped write/read pairs
  localparam int N_B2B = 32; // Write then read pairs
  // Cycles per test, end of test drain included
  localparam int MAX_CYCLES = 2 + 11 + (2 * N_RW + 3) + (3 * N_RO + 6) + 25 +
                              (2 * N_BAD + 3) + (2 * N_B2B + 3) + 40;

  typedef struct packed {
    logic        en;
    logic        wr;
    logic [1:0]  be;
    logic [7:0]  addr;
    logic [15:0] wdata;
  } req_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         bus_en;
  logic                         bus_wr;
  ctrl_reg_pkg::be_t            bus_be;
  ctrl_reg_pkg::addr_t          bus_addr;
  ctrl_reg_pkg::data_t          bus_wdata;
  ctrl_reg_pkg::data_t          bus_rdata;
  logic                         bus_rvalid;
  logic                         bus_err;
  ctrl_reg_pkg::data_t [7:0]    status_in;
  ctrl_reg_pkg::data_t          irq_set;
  ctrl_reg_pkg::data_t [7:0]    ctrl_values;
  logic                         irq;

  logic [15:0] m_val [0:7];        // Reference register map
  req_t        pend [$];           // Requests in flight, two deep
  logic [7:0][15:0] next_status;   // Driven at the next step
  logic [7:0][15:0] cur_status;    // Last driven, seen by the DUT at the next edge
  logic [15:0] next_irq_set;
  logic [15:0] cur_irq_set;
  logic [31:0] seed;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          test_errors;
  string       cur_test;

  ctrl_regs #(.NUM_REGS(8)) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_en      (bus_en),
    .bus_wr      (bus_wr),
    .bus_be      (bus_be),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_rdata   (bus_rdata),
    .bus_rvalid  (bus_rvalid),
    .bus_err     (bus_err),
    .status_in   (status_in),
    .irq_set     (irq_set),
    .ctrl_values (ctrl_values),
    .irq         (irq)
  );

  always #10 clk = ~clk; // 20 ns period

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run went past the limit of %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // Reset values of the register map
  function automatic logic [15:0] reset_value(input int idx);
    case (idx)
      1:       return 16'h0011; // MODE
      7:       return 16'hA5A5; // SCRATCH
      default: return 16'h0000;
    endcase
  endfunction

  function automatic logic is_ro_index(input int idx);
    return (idx == 4) || (idx == 5); // STATUS, FRAME_COUNT
  endfunction

  // One of CTRL, MODE, SCROLL_X, SCROLL_Y, SCRATCH
  function automatic logic [7:0] pick_rw_index();
    logic [31:0] r;
    r = next_rand();
    case (r % 5)
      0:       return 8'd0;
      1:       return 8'd1;
      2:       return 8'd2;
      3:       return 8'd3;
      default: return 8'd7;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: %s got %h expected %h at cycle %0d", cur_test, name, got, exp,
               cycles);
    end
  endtask

  // One clock: model the edge, drive the next request, check at the falling edge
  task automatic step(input logic en, input logic wr, input logic [1:0] be,
                      input logic [7:0] addr, input logic [15:0] wdata);
    req_t        due;
    req_t        req;
    logic        have_due;
    logic        exp_rvalid;
    logic        exp_err;
    logic [15:0] exp_rdata;
    logic [15:0] old_irq;
    logic        hit;
    logic [15:0] mask;
    logic [15:0] clr;
    @(posedge clk);
    old_irq    = m_val[6]; // irq is one edge behind IRQ_STATUS
    have_due   = 1'b0;
    exp_rvalid = 1'b0;
    exp_err    = 1'b0;
    exp_rdata  = 16'h0000;
    due        = '0;
    if (pend.size() == 2) begin
      due      = pend.pop_front(); // Driven two edges ago, answered at this edge
      have_due = 1'b1;
    end
    if (have_due && due.en) begin
      if (due.addr >= 8 || (due.wr && is_ro_index(due.addr))) begin
        exp_rvalid = 1'b1; // Error response, zero data
        exp_err    = 1'b1;
      end else if (!due.wr) begin
        exp_rvalid = 1'b1;
        exp_rdata  = m_val[due.addr[2:0]]; // Value before this edge
      end
    end
    // Slice edge
    mask = {{8{due.be[1]}}, {8{due.be[0]}}};
    for (int i = 0; i < 8; i++) begin
      hit = have_due && due.en && due.wr && (due.addr == i) && !is_ro_index(i);
      clr = hit ? (due.wdata & mask) : 16'h0000;
      if (is_ro_index(i)) begin
        m_val[i] = cur_status[i];
      end else if (i == 6) begin
        m_val[i] = (m_val[i] & ~clr) | cur_irq_set; // Set beats clear
      end else if (hit) begin
        m_val[i] = (m_val[i] & ~mask) | (due.wdata & mask);
      end
    end
    bus_en      <= en;
    bus_wr      <= wr;
    bus_be      <= be;
    bus_addr    <= addr;
    bus_wdata   <= wdata;
    status_in   <= next_status;
    irq_set     <= next_irq_set;
    cur_status  = next_status;
    cur_irq_set = next_irq_set;
    req = '{en: en, wr: wr, be: be, addr: addr, wdata: wdata};
    pend.push_back(req);
    @(negedge clk);
    check_value("bus_rvalid", {15'b0, bus_rvalid}, {15'b0, exp_rvalid});
    check_value("bus_err", {15'b0, bus_err}, {15'b0, exp_err});
    if (exp_rvalid) begin
      check_value("bus_rdata", bus_rdata, exp_rdata);
    end
    check_value("irq", {15'b0, irq}, {15'b0, (old_irq != 16'h0000)});
    for (int i = 0; i < 8; i++) begin
      check_value($sformatf("ctrl_values[%0d]", i), ctrl_values[i], m_val[i]);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 1'b0, 2'b00, 8'h00, 16'h0000);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [1:0] be,
                           input logic [15:0] data);
    step(1'b1, 1'b1, be, addr, data);
  endtask

  task automatic read_reg(input logic [7:0] addr);
    step(1'b1, 1'b0, 2'b00, addr, 16'h0000);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    idle(3); // Drain responses
    tests++;
    $display("%s: finished with %0d errors", cur_test, errors - test_errors);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  addr;
    logic [15:0] data;
    rst_n        = 1'b0;
    bus_en       = 1'b0;
    bus_wr       = 1'b0;
    bus_be       = '0;
    bus_addr     = '0;
    bus_wdata    = '0;
    status_in    = '0;
    irq_set      = '0;
    next_status  = '0;
    cur_status   = '0;
    next_irq_set = '0;
    cur_irq_set  = '0;
    seed         = 32'h78f0_edcb;
    for (int i = 0; i < 8; i++) begin
      m_val[i] = reset_value(i);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("reset_values"); // Status held at zero
    for (int a = 0; a < 8; a++) begin
      read_reg(8'(a));
    end
    end_test();

    begin_test("rw_random");
    for (int k = 0; k < N_RW; k++) begin
      rnd = next_rand();
      write_reg(pick_rw_index(), rnd[17:16], rnd[15:0]);
      read_reg(pick_rw_index());
    end
    end_test();

    begin_test("ro_status");
    for (int k = 0; k < N_RO; k++) begin
      rnd            = next_rand();
      next_status[4] = rnd[15:0];
      next_status[5] = rnd[31:16];
      idle(1);
      read_reg(8'd4);
      read_reg(8'd5);
    end
    rnd = next_rand();
    write_reg(8'd4, 2'b11, rnd[15:0]); // Rejected with bus_err
    write_reg(8'd5, 2'b11, rnd[31:16]);
    read_reg(8'd4);
    end_test();

    begin_test("irq_w1c");
    next_irq_set = 16'h8421;
    idle(1);
    next_irq_set = 16'h0000;
    idle(3);
    check_value("irq after set", {15'b0, irq}, 16'h0001);
    read_reg(8'd6);
    write_reg(8'd6, 2'b01, 16'hFFFF); // Low byte only
    idle(3);
    next_irq_set = 16'h0F00;
    idle(1);
    next_irq_set = 16'h0000;
    idle(2);
    write_reg(8'd6, 2'b11, 16'h0F00);
    next_irq_set = 16'h0300; // Lands on the same edge as the clear
    idle(1);
    next_irq_set = 16'h0000;
    idle(3);
    check_value("ctrl_values[6] set bits", ctrl_values[6] & 16'h0300, 16'h0300);
    write_reg(8'd6, 2'b11, 16'hFFFF);
    idle(3);
    check_value("irq after clear", {15'b0, irq}, 16'h0000);
    read_reg(8'd6);
    end_test();

    begin_test("unmapped");
    for (int k = 0; k < N_BAD; k++) begin
      rnd  = next_rand();
      addr = (k == 0) ? 8'd8 : 8'd8 + 8'(rnd % 248);
      write_reg(addr, 2'b11, rnd[31:16]);
      read_reg(addr);
    end
    end_test();

    begin_test("back_to_back");
    for (int k = 0; k < N_B2B; k++) begin
      rnd  = next_rand();
      addr = pick_rw_index();
      data = rnd[15:0];
      write_reg(addr, rnd[17:16] | 2'b01, data);
      read_reg(addr); // Must see the new value
    end
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/ctrl_reg_pkg.sv
hdl/reg_write_if.sv
hdl/reg_bus_decoder.sv
hdl/reg_slice.sv
hdl/reg_read_mux.sv
hdl/ctrl_regs.sv
tb/ctrl_regs_tb.sv

// File: Bender.yml
package:
  name: ctrl_regs

sources:
  # Package first, then the interface, then the modules bottom up
  - hdl/ctrl_reg_pkg.sv
  - hdl/reg_write_if.sv
  - hdl/reg_bus_decoder.sv
  - hdl/reg_slice.sv
  - hdl/reg_read_mux.sv
  - hdl/ctrl_regs.sv
  - target: test
    files:
      - tb/ctrl_regs_tb.sv
